//--- hw/uart_pkg.sv
//**************************************************************************
// UART peripheral package
// Bus widths, FIFO depths, register index and layouts, and the framer
// state encodings shared by the register block and the UART core.
//**************************************************************************

package uart_pkg;

    localparam int D_WIDTH  = 32;
    localparam int A_WIDTH  = 8;
    localparam int TX_DEPTH = 16;
    localparam int RX_DEPTH = 32;

    typedef logic [7:0]         byte_t;
    typedef logic [D_WIDTH-1:0] bus_data_t;
    typedef logic [A_WIDTH-1:0] bus_addr_t;
    typedef logic [31:0]        baud_div_t;

    // storage always spans RX_DEPTH, the count needs one extra bit for full
    typedef logic [$clog2(RX_DEPTH)-1:0] fifo_ptr_t;
    typedef logic [$clog2(RX_DEPTH):0]   fifo_cnt_t;

    // register index taken from address bits 3:2
    typedef enum logic [1:0] {
        REG_CTRL_0  = 2'd0,
        REG_CTRL_1  = 2'd1,
        REG_DATA_TX = 2'd2,
        REG_DATA_RX = 2'd3
    } uart_reg_e;

    typedef struct packed {
        baud_div_t baud;
    } ctrl_0_t;

    typedef struct packed {
        logic [30:0] rsvd;
        logic        core_rst_n;
    } ctrl_1_t;

    typedef struct packed {
        logic [22:0] rsvd;
        logic        tx_flag;
        byte_t       tx_data;
    } data_tx_t;

    typedef struct packed {
        logic [22:0] rsvd;
        logic        rx_flag;
        byte_t       rx_data;
    } data_rx_t;

    typedef struct packed {
        byte_t data;
        logic  valid;
    } byte_stream_t;

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;
    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

endpackage

//--- hw/uart_bit_timer.sv
//**************************************************************************
// UART bit timer
// Down-counter that pulses once per bit period. A restart reloads it with
// the full divisor, or with half of it to land on the middle of a bit.
//**************************************************************************

`timescale 1ns/1ps

module uart_bit_timer (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  uart_pkg::baud_div_t div_i,
    input  logic                restart_i,
    input  logic                half_i,
    output logic                tick_o
);

    import uart_pkg::*;

    baud_div_t cnt;
    baud_div_t load;

    assign load = half_i ? (div_i >> 1) : div_i;

    // a restart in the same cycle wins over a stale tick
    assign tick_o = (cnt == '0) && !restart_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt <= '0;
        end else if (restart_i) begin
            cnt <= (load == '0) ? '0 : load - 1'b1;
        end else if (cnt == '0) begin
            cnt <= (div_i == '0) ? '0 : div_i - 1'b1;
        end else begin
            cnt <= cnt - 1'b1;
        end
    end

endmodule

//--- hw/uart_fifo.sv
//**************************************************************************
// UART byte FIFO
// Circular buffer with valid/ready on both sides. The storage spans the
// larger depth and limit_i caps how many entries an instance may hold.
//**************************************************************************

`timescale 1ns/1ps

module uart_fifo (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  uart_pkg::fifo_cnt_t    limit_i,
    input  uart_pkg::byte_stream_t push_i,
    output logic                   ready_o,
    output uart_pkg::byte_stream_t pop_o,
    input  logic                   pop_ready_i
);

    import uart_pkg::*;

    byte_t     mem [RX_DEPTH];
    fifo_ptr_t wr_ptr;
    fifo_ptr_t rd_ptr;
    fifo_cnt_t count;
    fifo_cnt_t count_next;
    logic      do_push;
    logic      do_pop;

    assign do_push = push_i.valid && ready_o;
    assign do_pop  = pop_o.valid && pop_ready_i;

    assign pop_o.valid = (count != '0);
    assign pop_o.data  = mem[rd_ptr];

    always_comb begin
        count_next = count;
        if (do_push && !do_pop) begin
            count_next = count + 1'b1;
        end else if (do_pop && !do_push) begin
            count_next = count - 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr] <= push_i.data;
        end
    end

    // ready is registered so it stays low while the core is held in reset
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            ready_o <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count   <= count_next;
            ready_o <= (count_next < limit_i);
        end
    end

    assert property (@(posedge clk_i) disable iff (!rst_n_i) count <= limit_i)
        else $error("fifo count above its depth");

endmodule

//--- hw/uart_tx.sv
//**************************************************************************
// UART transmitter
// Serializes one byte per frame as a start bit, 8 data bits LSB first and
// a stop bit, each held for one bit timer period.
//**************************************************************************

`timescale 1ns/1ps

module uart_tx (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  uart_pkg::byte_stream_t in_i,
    output logic                   ready_o,
    input  logic                   tick_i,
    output logic                   restart_o,
    output logic                   tx_o
);

    import uart_pkg::*;

    tx_state_e  state;
    byte_t      shift;
    logic [2:0] bit_cnt;

    // a byte is only taken between frames
    assign ready_o   = (state == TX_IDLE);
    assign restart_o = ready_o && in_i.valid;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state   <= TX_IDLE;
            shift   <= '0;
            bit_cnt <= '0;
            tx_o    <= 1'b1;
        end else begin
            case (state)
                TX_IDLE: begin
                    tx_o <= 1'b1;
                    if (in_i.valid) begin
                        shift <= in_i.data;
                        tx_o  <= 1'b0;
                        state <= TX_START;
                    end
                end
                TX_START: if (tick_i) begin
                    tx_o    <= shift[0];
                    shift   <= shift >> 1;
                    bit_cnt <= '0;
                    state   <= TX_DATA;
                end
                TX_DATA: if (tick_i) begin
                    if (bit_cnt == 3'd7) begin
                        tx_o  <= 1'b1;
                        state <= TX_STOP;
                    end else begin
                        tx_o    <= shift[0];
                        shift   <= shift >> 1;
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                TX_STOP: if (tick_i) begin
                    state <= TX_IDLE;
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

endmodule

//--- hw/uart_rx.sv
//**************************************************************************
// UART receiver
// Finds the falling edge of a start bit, samples each bit at its middle
// and hands the byte on when the stop bit reads high.
//**************************************************************************

`timescale 1ns/1ps

module uart_rx (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   rx_i,
    input  logic                   tick_i,
    output logic                   restart_o,
    output logic                   half_o,
    output uart_pkg::byte_stream_t out_o
);

    import uart_pkg::*;

    rx_state_e  state;
    byte_t      shift;
    logic [2:0] bit_cnt;
    logic       rx_meta;
    logic       rx_sync;
    logic       rx_prev;
    logic       fall;

    assign fall = rx_prev && !rx_sync;

    // the first tick after a start edge falls half a bit later
    assign restart_o = (state == RX_IDLE) && fall;
    assign half_o    = (state == RX_IDLE);

    assign out_o.valid = (state == RX_STOP) && tick_i && rx_sync;
    assign out_o.data  = shift;

    // the line idles high, so the synchronizer resets to 1
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx_i;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state   <= RX_IDLE;
            shift   <= '0;
            bit_cnt <= '0;
        end else begin
            case (state)
                RX_IDLE: if (fall) begin
                    state <= RX_START;
                end
                // a glitch that is gone by mid-bit is not a start bit
                RX_START: if (tick_i) begin
                    bit_cnt <= '0;
                    state   <= rx_sync ? RX_IDLE : RX_DATA;
                end
                RX_DATA: if (tick_i) begin
                    shift <= {rx_sync, shift[7:1]};
                    if (bit_cnt == 3'd7) begin
                        state <= RX_STOP;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                RX_STOP: if (tick_i) begin
                    state <= RX_IDLE;
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

endmodule

//--- hw/uart_core.sv
//**************************************************************************
// UART core
// Transmit FIFO feeding the transmitter and the receiver feeding the
// receive FIFO, each framer paced by its own bit timer.
//**************************************************************************

`timescale 1ns/1ps

module uart_core (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  uart_pkg::baud_div_t    baud_div_i,
    input  uart_pkg::byte_stream_t tx_in_i,
    output logic                   tx_ready_o,
    output uart_pkg::byte_stream_t rx_out_o,
    input  logic                   rx_pop_i,
    input  logic                   rx_i,
    output logic                   tx_o
);

    import uart_pkg::*;

    byte_stream_t tx_stream;
    byte_stream_t rx_stream;
    logic         tx_take;
    logic         tx_tick;
    logic         tx_restart;
    logic         rx_tick;
    logic         rx_restart;
    logic         rx_half;

    uart_fifo u_tx_fifo (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .limit_i     (fifo_cnt_t'(TX_DEPTH)),
        .push_i      (tx_in_i),
        .ready_o     (tx_ready_o),
        .pop_o       (tx_stream),
        .pop_ready_i (tx_take)
    );

    uart_bit_timer u_tx_timer (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .div_i     (baud_div_i),
        .restart_i (tx_restart),
        .half_i    (1'b0),
        .tick_o    (tx_tick)
    );

    uart_tx u_tx (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .in_i      (tx_stream),
        .ready_o   (tx_take),
        .tick_i    (tx_tick),
        .restart_o (tx_restart),
        .tx_o      (tx_o)
    );

    uart_bit_timer u_rx_timer (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .div_i     (baud_div_i),
        .restart_i (rx_restart),
        .half_i    (rx_half),
        .tick_o    (rx_tick)
    );

    uart_rx u_rx (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .rx_i      (rx_i),
        .tick_i    (rx_tick),
        .restart_o (rx_restart),
        .half_o    (rx_half),
        .out_o     (rx_stream)
    );

    // the receiver cannot wait, a byte arriving at a full FIFO is lost
    uart_fifo u_rx_fifo (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .limit_i     (fifo_cnt_t'(RX_DEPTH)),
        .push_i      (rx_stream),
        .ready_o     (),
        .pop_o       (rx_out_o),
        .pop_ready_i (rx_pop_i)
    );

endmodule

//--- hw/mmio_uart.sv
//**************************************************************************
// Memory-mapped UART
// Register block on a simple strobe bus holding the divisor, the core's
// soft reset and the transmit staging register, in front of the UART core.
//**************************************************************************

`timescale 1ns/1ps

module mmio_uart (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                wr_en_i,
    input  uart_pkg::bus_addr_t wr_addr_i,
    input  uart_pkg::bus_data_t wr_data_i,
    input  logic                rd_en_i,
    input  uart_pkg::bus_addr_t rd_addr_i,
    output uart_pkg::bus_data_t rd_data_o,
    input  logic                rx_i,
    output logic                tx_o
);

    import uart_pkg::*;

    ctrl_0_t      ctrl_0;
    ctrl_1_t      ctrl_1;
    byte_stream_t tx_stage;
    logic         tx_ready;
    byte_stream_t rx_out;
    logic         rx_pop;
    uart_reg_e    wr_reg;
    uart_reg_e    rd_reg;
    data_tx_t     data_tx;
    data_rx_t     data_rx;
    bus_data_t    rd_word;

    assign wr_reg = uart_reg_e'(wr_addr_i[3:2]);
    assign rd_reg = uart_reg_e'(rd_addr_i[3:2]);

    // one read of DATA_RX removes exactly the byte it returns
    assign rx_pop = rd_en_i && (rd_reg == REG_DATA_RX) && rx_out.valid;

    always_comb begin
        data_tx         = '0;
        data_tx.tx_flag = tx_ready;
        data_tx.tx_data = tx_stage.data;
        data_rx         = '0;
        data_rx.rx_flag = rx_out.valid;
        data_rx.rx_data = rx_out.data;
        case (rd_reg)
            REG_CTRL_0:  rd_word = ctrl_0;
            REG_CTRL_1:  rd_word = ctrl_1;
            REG_DATA_TX: rd_word = data_tx;
            default:     rd_word = data_rx;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_data_o <= '0;
        end else if (rd_en_i) begin
            rd_data_o <= rd_word;
        end
    end

    // a staged byte waits for FIFO space, a new write replaces it
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ctrl_0   <= '0;
            ctrl_1   <= '0;
            tx_stage <= '0;
        end else begin
            if (tx_stage.valid && tx_ready) begin
                tx_stage.valid <= 1'b0;
            end
            if (wr_en_i) begin
                case (wr_reg)
                    REG_CTRL_0: ctrl_0.baud <= wr_data_i;
                    REG_CTRL_1: ctrl_1.core_rst_n <= wr_data_i[0];
                    REG_DATA_TX: begin
                        tx_stage.data  <= wr_data_i[7:0];
                        tx_stage.valid <= 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

    uart_core u_core (
        .clk_i      (clk_i),
        .rst_n_i    (ctrl_1.core_rst_n),
        .baud_div_i (ctrl_0.baud),
        .tx_in_i    (tx_stage),
        .tx_ready_o (tx_ready),
        .rx_out_o   (rx_out),
        .rx_pop_i   (rx_pop),
        .rx_i       (rx_i),
        .tx_o       (tx_o)
    );

    assert property (@(posedge clk_i) disable iff (!rst_n_i) rx_pop |-> rx_out.valid)
        else $error("receive pop without a valid byte");

    // a core held in reset keeps the line idle and both FIFO sides closed
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !ctrl_1.core_rst_n |-> tx_o && !tx_ready && !rx_out.valid)
        else $error("core outputs active while the core is in reset");

endmodule

//--- sim/tb_clk_gen.sv
//**************************************************************************
// Testbench clock source
// Free-running clock with an 8 ns period
//**************************************************************************

`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    always #4 clk_o = ~clk_o;

endmodule

//--- sim/tb_mmio_uart.sv
//**************************************************************************
// Memory-mapped UART testbench
// Drives the register bus, loops tx_o back into rx_i, decodes the serial
// line against a reference frame and checks the bytes read from DATA_RX.
//**************************************************************************

`timescale 1ns/1ps

module tb_mmio_uart;

    import uart_pkg::*;

    localparam baud_div_t TEST_DIV   = 32'd16;
    localparam int        POLL_LIMIT = 2000;
    localparam int        TX_LIMIT   = 20000;
    localparam int        FILL_LIMIT = 64;

    logic        clk;
    logic        rst_n;
    logic        wr_en;
    bus_addr_t   wr_addr;
    bus_data_t   wr_data;
    logic        rd_en;
    bus_addr_t   rd_addr;
    bus_data_t   rd_data;
    logic        tx;
    logic [31:0] lfsr;
    int          err_count;
    int          timeout_count;
    logic        monitor_en;
    byte_t       last_tx;
    byte_t       tx_expect_q[$];
    byte_t       rx_expect_q[$];

    tb_clk_gen i_clk_gen (
        .clk_o (clk)
    );

    // rx_i is looped back from tx_o
    mmio_uart i_dut (
        .clk_i     (clk),
        .rst_n_i   (rst_n),
        .wr_en_i   (wr_en),
        .wr_addr_i (wr_addr),
        .wr_data_i (wr_data),
        .rd_en_i   (rd_en),
        .rd_addr_i (rd_addr),
        .rd_data_o (rd_data),
        .rx_i      (tx),
        .tx_o      (tx)
    );

    // bit 0 goes on the line first: start, data LSB first, stop
    function automatic logic [9:0] frame_bits(byte_t b);
        return {1'b1, b, 1'b0};
    endfunction

    function automatic bus_addr_t reg_addr(uart_reg_e r);
        return bus_addr_t'({r, 2'b00});
    endfunction

    // taps at 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_byte(output byte_t b);
        for (int i = 0; i < 8; i++) begin
            lfsr = lfsr_step(lfsr);
            b[i] = lfsr[0];
        end
    endtask

    task automatic check_word(string name, bus_data_t got, bus_data_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_byte(string name, byte_t got, byte_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_line(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s got %b expected %b", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic write_reg(uart_reg_e r, bus_data_t d);
        @(posedge clk);
        #1;
        wr_en   = 1'b1;
        wr_addr = reg_addr(r);
        wr_data = d;
        @(posedge clk);
        #1;
        wr_en = 1'b0;
    endtask

    // rd_data_o is registered at the edge that sees rd_en_i
    task automatic read_reg(uart_reg_e r, output bus_data_t d);
        @(posedge clk);
        #1;
        rd_en   = 1'b1;
        rd_addr = reg_addr(r);
        @(posedge clk);
        #1;
        rd_en = 1'b0;
        d     = rd_data;
    endtask

    task automatic write_tx_byte(byte_t b);
        write_reg(REG_DATA_TX, {24'd0, b});
        tx_expect_q.push_back(b);
        rx_expect_q.push_back(b);
        last_tx = b;
    endtask

    task automatic send_byte(byte_t b);
        bus_data_t word;
        data_tx_t  d;
        int        polls;
        polls = 0;
        do begin
            read_reg(REG_DATA_TX, word);
            d = data_tx_t'(word);
            polls++;
        end while (!d.tx_flag && polls < POLL_LIMIT);
        check_byte("tx_data", d.tx_data, last_tx);
        if (!d.tx_flag) begin
            $display("timeout waiting for tx_flag before a DATA_TX write");
            timeout_count++;
        end else begin
            write_tx_byte(b);
        end
    endtask

    task automatic receive_byte(byte_t exp);
        bus_data_t word;
        data_rx_t  d;
        int        polls;
        polls = 0;
        do begin
            read_reg(REG_DATA_RX, word);
            d = data_rx_t'(word);
            polls++;
        end while (!d.rx_flag && polls < POLL_LIMIT);
        if (!d.rx_flag) begin
            $display("timeout waiting for a received byte on DATA_RX");
            timeout_count++;
        end else begin
            check_word("DATA_RX", word, {23'd0, 1'b1, exp});
        end
    endtask

    // the data field has no meaning while rx_flag is clear
    task automatic check_rx_empty();
        bus_data_t word;
        read_reg(REG_DATA_RX, word);
        check_word("DATA_RX", {word[31:8], 8'h00}, '0);
    endtask

    task automatic wait_tx_done();
        int cycles;
        cycles = 0;
        while (tx_expect_q.size() != 0 && cycles < TX_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (tx_expect_q.size() != 0) begin
            $display("timeout waiting for %0d frames on tx_o", tx_expect_q.size());
            timeout_count++;
        end
    endtask

    task automatic drain_rx();
        while (rx_expect_q.size() != 0) begin
            receive_byte(rx_expect_q.pop_front());
        end
    endtask

    // one sample per clock at the falling edge, every bit must hold for TEST_DIV samples
    initial begin : serial_monitor
        logic       prev;
        logic       level;
        logic [9:0] frame;
        byte_t      exp_byte;
        prev = 1'b1;
        forever begin
            @(negedge clk);
            if (monitor_en && prev && !tx) begin
                for (int i = 0; i < 10; i++) begin
                    for (int s = 0; s < int'(TEST_DIV); s++) begin
                        if (i != 0 || s != 0) begin
                            @(negedge clk);
                        end
                        if (s == 0) begin
                            level = tx;
                        end else begin
                            check_line("tx_o", tx, level);
                        end
                    end
                    frame[i] = level;
                end
                if (tx_expect_q.size() == 0) begin
                    $display("a frame appeared on tx_o with no byte written");
                    err_count++;
                end else begin
                    exp_byte = tx_expect_q.pop_front();
                    check_word("tx_o frame", bus_data_t'(frame),
                               bus_data_t'(frame_bits(exp_byte)));
                end
                prev = 1'b1;
            end else begin
                prev = tx;
            end
        end
    end

    initial begin : stimulus
        bus_data_t word;
        bus_data_t pattern;
        data_tx_t  dtx;
        byte_t     b;
        int        tries;
        int        edges;
        int        cycles;
        logic      full_seen;
        logic      tx_prev;

        lfsr          = 32'hc6ac_31e6;
        err_count     = 0;
        timeout_count = 0;
        monitor_en    = 1'b1;
        last_tx       = '0;
        rst_n         = 1'b0;
        wr_en         = 1'b0;
        wr_addr       = '0;
        wr_data       = '0;
        rd_en         = 1'b0;
        rd_addr       = '0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // everything reads zero and the core is held in reset
        read_reg(REG_CTRL_0, word);
        check_word("CTRL_0", word, '0);
        read_reg(REG_CTRL_1, word);
        check_word("CTRL_1", word, '0);
        read_reg(REG_DATA_TX, word);
        check_word("DATA_TX", word, '0);
        check_rx_empty();
        check_line("tx_o", tx, 1'b1);

        pattern = '0;
        for (int n = 0; n < 4; n++) begin
            rand_byte(b);
            pattern = {pattern[23:0], b};
        end
        write_reg(REG_CTRL_0, pattern);
        read_reg(REG_CTRL_0, word);
        check_word("CTRL_0", word, pattern);
        // only bit 0 of CTRL_1 is stored
        write_reg(REG_CTRL_1, 32'hffff_fffe);
        read_reg(REG_CTRL_1, word);
        check_word("CTRL_1", word, 32'h0000_0000);
        write_reg(REG_CTRL_0, TEST_DIV);
        read_reg(REG_CTRL_0, word);
        check_word("CTRL_0", word, TEST_DIV);
        write_reg(REG_CTRL_1, 32'h0000_0001);
        read_reg(REG_CTRL_1, word);
        check_word("CTRL_1", word, 32'h0000_0001);

        for (int n = 0; n < 4; n++) begin
            rand_byte(b);
            send_byte(b);
        end
        wait_tx_done();
        drain_rx();
        check_rx_empty();

        // write while tx_flag allows it until the transmit FIFO fills
        tries     = 0;
        full_seen = 1'b0;
        while (!full_seen && tries < FILL_LIMIT) begin
            read_reg(REG_DATA_TX, word);
            dtx = data_tx_t'(word);
            check_byte("tx_data", dtx.tx_data, last_tx);
            if (dtx.tx_flag) begin
                rand_byte(b);
                write_tx_byte(b);
            end else begin
                full_seen = 1'b1;
            end
            tries++;
        end
        if (!full_seen) begin
            $display("tx_flag never dropped while the transmit FIFO was being filled");
            err_count++;
        end
        wait_tx_done();
        drain_rx();
        check_rx_empty();

        // soft reset in the start bit of the second frame, once the first byte is received
        monitor_en = 1'b0;
        for (int n = 0; n < 3; n++) begin
            rand_byte(b);
            write_reg(REG_DATA_TX, {24'd0, b});
            last_tx = b;
        end
        edges   = 0;
        cycles  = 0;
        tx_prev = 1'b1;
        while (edges < 2 && cycles < TX_LIMIT) begin
            @(negedge clk);
            if (tx_prev && !tx) begin
                edges++;
                // skip to the middle of the stop bit so data edges are not taken for a start
                if (edges == 1) begin
                    repeat (9 * int'(TEST_DIV) + int'(TEST_DIV) / 2) @(negedge clk);
                end
            end
            tx_prev = tx;
            cycles++;
        end
        if (edges < 2) begin
            $display("timeout waiting for the second start bit on tx_o");
            timeout_count++;
        end
        write_reg(REG_CTRL_1, 32'h0000_0000);
        check_line("tx_o", tx, 1'b1);
        check_rx_empty();
        read_reg(REG_DATA_TX, word);
        check_word("DATA_TX", word, {23'd0, 1'b0, last_tx});
        // with the core running again nothing left in the transmit FIFO may go out
        write_reg(REG_CTRL_1, 32'h0000_0001);
        for (int n = 0; n < 4 * int'(TEST_DIV); n++) begin
            @(negedge clk);
            check_line("tx_o", tx, 1'b1);
        end

        $display("errors: %0d mismatches, %0d timeouts", err_count, timeout_count);
        if (err_count == 0 && timeout_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- sim.f
hw/uart_pkg.sv
hw/uart_bit_timer.sv
hw/uart_fifo.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_core.sv
hw/mmio_uart.sv
sim/tb_clk_gen.sv
sim/tb_mmio_uart.sv
